// ==== verilog/mesh_pkg.sv ====
// Mesh NoC shared definitions
// Packet format, router port numbering and field widths

package mesh_pkg;

  // Field widths
  // ------------------------------
  localparam int COORD_W   = 3;   // Meshes up to 8 x 8
  localparam int PAYLOAD_W = 16;
  localparam int NUM_PORTS = 5;   // Local plus four sides

  // Single-flit packet, 28 bits in total
  typedef struct packed {
    logic [COORD_W-1:0]   dest_x;   // Destination column
    logic [COORD_W-1:0]   dest_y;   // Destination row
    logic [COORD_W-1:0]   src_x;    // Source column, carried for the node
    logic [COORD_W-1:0]   src_y;    // Source row
    logic [PAYLOAD_W-1:0] payload;
  } packet_t;

  // Router port numbers, also the index into every per-port array
  typedef enum logic [2:0] {
    LOCAL = 3'd0,   // Attached node
    NORTH = 3'd1,   // Towards increasing y
    EAST  = 3'd2,   // Towards increasing x
    SOUTH = 3'd3,
    WEST  = 3'd4
  } port_t;

endpackage

// ==== verilog/mesh_input_fifo.sv ====
// Router input buffer
// Circular FIFO per port, enable level raised while space remains

`timescale 1ns/1ps

module mesh_input_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              i_rst,
  input  mesh_pkg::packet_t i_data,       // From upstream router or node
  input  logic              i_data_val,
  output logic              o_en,         // Space available
  output mesh_pkg::packet_t o_head,       // Oldest entry
  output logic              o_head_val,
  input  logic              i_pop         // Head taken by the arbiter
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  mesh_pkg::packet_t mem [FIFO_DEPTH];   // Storage, no reset
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              wr;
  logic              rd;

  assign o_en       = (count < CNT_W'(FIFO_DEPTH));   // Independent of valid
  assign o_head_val = (count != '0);
  assign o_head     = mem[rd_ptr];

  assign wr = i_data_val && o_en;   // Transfer accepted
  assign rd = i_pop && o_head_val;

  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // Wrap
      if (rd)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr && !rd)
        count <= count + 1'b1;
      else if (rd && !wr)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr)
      mem[wr_ptr] <= i_data;
  end

endmodule

// ==== verilog/mesh_route_arbiter.sv ====
// Router route and arbitration stage
// XY route per input head, round-robin grant per free output

`timescale 1ns/1ps

module mesh_route_arbiter #(
  parameter int X_LOC = 0,
  parameter int Y_LOC = 0
) (
  input  logic              clk,
  input  logic              i_rst,
  input  mesh_pkg::packet_t i_head     [mesh_pkg::NUM_PORTS],   // FIFO heads, per input
  input  logic              i_head_val [mesh_pkg::NUM_PORTS],
  input  logic              i_out_free [mesh_pkg::NUM_PORTS],   // Output register can load
  output logic              o_pop      [mesh_pkg::NUM_PORTS],   // Per input
  output mesh_pkg::port_t   o_sel      [mesh_pkg::NUM_PORTS],   // Winning input, per output
  output logic              o_load     [mesh_pkg::NUM_PORTS]    // Per output
);

  localparam int NUM = mesh_pkg::NUM_PORTS;
  localparam logic [mesh_pkg::COORD_W-1:0] MY_X = X_LOC[mesh_pkg::COORD_W-1:0];
  localparam logic [mesh_pkg::COORD_W-1:0] MY_Y = Y_LOC[mesh_pkg::COORD_W-1:0];

  mesh_pkg::port_t route  [NUM];   // Requested output of each head
  logic [2:0]      rr_ptr [NUM];   // First input to try, per output
  logic [2:0]      win    [NUM];   // Granted input, per output

  // Step 1, XY route
  // ------------------------------
  always_comb begin
    for (int i = 0; i < NUM; i++) begin
      if (i_head[i].dest_x > MY_X)
        route[i] = mesh_pkg::EAST;    // X first
      else if (i_head[i].dest_x < MY_X)
        route[i] = mesh_pkg::WEST;
      else if (i_head[i].dest_y > MY_Y)
        route[i] = mesh_pkg::NORTH;   // Column matches, now Y
      else if (i_head[i].dest_y < MY_Y)
        route[i] = mesh_pkg::SOUTH;
      else
        route[i] = mesh_pkg::LOCAL;   // Arrived
    end
  end

  // Step 2, round-robin grant
  // ------------------------------
  always_comb begin
    int idx;
    for (int o = 0; o < NUM; o++) begin
      o_load[o] = 1'b0;
      win[o]    = rr_ptr[o];
      // Scan inputs starting at the pointer, first requester wins
      for (int k = 0; k < NUM; k++) begin
        idx = (int'(rr_ptr[o]) + k) % NUM;
        if (!o_load[o] && i_out_free[o] && i_head_val[idx] &&
            route[idx] == mesh_pkg::port_t'(o)) begin
          o_load[o] = 1'b1;
          win[o]    = idx[2:0];
        end
      end
      o_sel[o] = mesh_pkg::port_t'(win[o]);
    end
  end

  // One destination per head, so at most one grant per input
  always_comb begin
    for (int i = 0; i < NUM; i++) begin
      o_pop[i] = 1'b0;
      for (int o = 0; o < NUM; o++)
        if (o_load[o] && win[o] == 3'(i))
          o_pop[i] = 1'b1;
    end
  end

  // Pointer moves past the winner
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int o = 0; o < NUM; o++)
        rr_ptr[o] <= '0;
    end else begin
      for (int o = 0; o < NUM; o++)
        if (o_load[o])
          rr_ptr[o] <= (win[o] == 3'(NUM - 1)) ? 3'd0 : win[o] + 3'd1;
    end
  end

endmodule

// ==== verilog/mesh_router.sv ====
// Five-port mesh router
// Input FIFOs, route and arbitrate stage, registered outputs

`timescale 1ns/1ps

module mesh_router #(
  parameter int X_LOC      = 0,
  parameter int Y_LOC      = 0,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              i_rst,
  // Receive side, valid/enable
  input  mesh_pkg::packet_t i_data     [mesh_pkg::NUM_PORTS],
  input  logic              i_data_val [mesh_pkg::NUM_PORTS],
  output logic              o_en       [mesh_pkg::NUM_PORTS],
  // Send side, valid/enable
  output mesh_pkg::packet_t o_data     [mesh_pkg::NUM_PORTS],
  output logic              o_data_val [mesh_pkg::NUM_PORTS],
  input  logic              i_en       [mesh_pkg::NUM_PORTS]
);

  localparam int NUM = mesh_pkg::NUM_PORTS;

  mesh_pkg::packet_t head     [NUM];   // FIFO heads
  logic              head_val [NUM];
  logic              pop      [NUM];
  logic              out_free [NUM];
  logic              load     [NUM];
  mesh_pkg::port_t   sel      [NUM];   // Input feeding each output

  // Input buffer stage
  // ------------------------------
  for (genvar p = 0; p < NUM; p++) begin : g_port
    mesh_input_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) in_fifo_i (
      .clk,
      .i_rst,
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),
      .o_head     (head[p]),
      .o_head_val (head_val[p]),
      .i_pop      (pop[p])
    );

    // Empty, or emptying on this edge
    assign out_free[p] = !o_data_val[p] || i_en[p];
  end

  // Route and arbitrate stage
  // ------------------------------
  mesh_route_arbiter #(
    .X_LOC (X_LOC),
    .Y_LOC (Y_LOC)
  ) route_arb_i (
    .clk,
    .i_rst,
    .i_head     (head),
    .i_head_val (head_val),
    .i_out_free (out_free),
    .o_pop      (pop),
    .o_sel      (sel),
    .o_load     (load)
  );

  // Output register stage
  // ------------------------------
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int o = 0; o < NUM; o++)
        o_data_val[o] <= 1'b0;
    end else begin
      for (int o = 0; o < NUM; o++) begin
        if (load[o])
          o_data_val[o] <= 1'b1;   // New packet, possibly back to back
        else if (i_en[o])
          o_data_val[o] <= 1'b0;   // Taken downstream
      end
    end
  end

  // Payload holds while enable is low
  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM; o++)
      if (load[o])
        o_data[o] <= head[sel[o]];
  end

endmodule

// ==== verilog/mesh_network.sv ====
// Mesh NoC top level
// Grid of X_NODES by Y_NODES routers, XY routed, node index y*X_NODES+x

`timescale 1ns/1ps

module mesh_network #(
  parameter int X_NODES    = 3,
  parameter int Y_NODES    = 3,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              i_rst,
  // Node to network
  input  mesh_pkg::packet_t i_data     [X_NODES*Y_NODES],
  input  logic              i_data_val [X_NODES*Y_NODES],
  output logic              o_en       [X_NODES*Y_NODES],
  // Network to node
  output mesh_pkg::packet_t o_data     [X_NODES*Y_NODES],
  output logic              o_data_val [X_NODES*Y_NODES],
  input  logic              i_en       [X_NODES*Y_NODES]
);

  localparam int NODES = X_NODES * Y_NODES;
  localparam int NUM   = mesh_pkg::NUM_PORTS;

  // Router links, [node][port]
  // ------------------------------
  mesh_pkg::packet_t rt_in_data  [NODES][NUM];
  logic              rt_in_val   [NODES][NUM];
  logic              rt_o_en     [NODES][NUM];
  mesh_pkg::packet_t rt_out_data [NODES][NUM];
  logic              rt_out_val  [NODES][NUM];
  logic              rt_i_en     [NODES][NUM];

  for (genvar y = 0; y < Y_NODES; y++) begin : g_row
    for (genvar x = 0; x < X_NODES; x++) begin : g_col
      localparam int N = y * X_NODES + x;

      // Local port straight to the node
      assign rt_in_data[N][mesh_pkg::LOCAL] = i_data[N];
      assign rt_in_val[N][mesh_pkg::LOCAL]  = i_data_val[N];
      assign o_en[N]                        = rt_o_en[N][mesh_pkg::LOCAL];
      assign o_data[N]                      = rt_out_data[N][mesh_pkg::LOCAL];
      assign o_data_val[N]                  = rt_out_val[N][mesh_pkg::LOCAL];
      assign rt_i_en[N][mesh_pkg::LOCAL]    = i_en[N];

      // North side, neighbour at y+1 sends on its south port
      if (y < Y_NODES - 1) begin : g_north
        assign rt_in_data[N][mesh_pkg::NORTH] = rt_out_data[N+X_NODES][mesh_pkg::SOUTH];
        assign rt_in_val[N][mesh_pkg::NORTH]  = rt_out_val[N+X_NODES][mesh_pkg::SOUTH];
        assign rt_i_en[N][mesh_pkg::NORTH]    = rt_o_en[N+X_NODES][mesh_pkg::SOUTH];
      end else begin : g_north_edge
        assign rt_in_data[N][mesh_pkg::NORTH] = '0;   // Mesh edge
        assign rt_in_val[N][mesh_pkg::NORTH]  = 1'b0;
        assign rt_i_en[N][mesh_pkg::NORTH]    = 1'b0;
      end

      // East side
      if (x < X_NODES - 1) begin : g_east
        assign rt_in_data[N][mesh_pkg::EAST] = rt_out_data[N+1][mesh_pkg::WEST];
        assign rt_in_val[N][mesh_pkg::EAST]  = rt_out_val[N+1][mesh_pkg::WEST];
        assign rt_i_en[N][mesh_pkg::EAST]    = rt_o_en[N+1][mesh_pkg::WEST];
      end else begin : g_east_edge
        assign rt_in_data[N][mesh_pkg::EAST] = '0;
        assign rt_in_val[N][mesh_pkg::EAST]  = 1'b0;
        assign rt_i_en[N][mesh_pkg::EAST]    = 1'b0;
      end

      // South side, neighbour at y-1 sends on its north port
      if (y > 0) begin : g_south
        assign rt_in_data[N][mesh_pkg::SOUTH] = rt_out_data[N-X_NODES][mesh_pkg::NORTH];
        assign rt_in_val[N][mesh_pkg::SOUTH]  = rt_out_val[N-X_NODES][mesh_pkg::NORTH];
        assign rt_i_en[N][mesh_pkg::SOUTH]    = rt_o_en[N-X_NODES][mesh_pkg::NORTH];
      end else begin : g_south_edge
        assign rt_in_data[N][mesh_pkg::SOUTH] = '0;
        assign rt_in_val[N][mesh_pkg::SOUTH]  = 1'b0;
        assign rt_i_en[N][mesh_pkg::SOUTH]    = 1'b0;
      end

      // West side
      if (x > 0) begin : g_west
        assign rt_in_data[N][mesh_pkg::WEST] = rt_out_data[N-1][mesh_pkg::EAST];
        assign rt_in_val[N][mesh_pkg::WEST]  = rt_out_val[N-1][mesh_pkg::EAST];
        assign rt_i_en[N][mesh_pkg::WEST]    = rt_o_en[N-1][mesh_pkg::EAST];
      end else begin : g_west_edge
        assign rt_in_data[N][mesh_pkg::WEST] = '0;
        assign rt_in_val[N][mesh_pkg::WEST]  = 1'b0;
        assign rt_i_en[N][mesh_pkg::WEST]    = 1'b0;
      end

      mesh_router #(
        .X_LOC      (x),
        .Y_LOC      (y),
        .FIFO_DEPTH (FIFO_DEPTH)
      ) router_i (
        .clk,
        .i_rst,
        .i_data     (rt_in_data[N]),    // From neighbours and node
        .i_data_val (rt_in_val[N]),
        .o_en       (rt_o_en[N]),       // Back to senders
        .o_data     (rt_out_data[N]),   // To neighbours and node
        .o_data_val (rt_out_val[N]),
        .i_en       (rt_i_en[N])        // From receivers
      );
    end
  end

endmodule

// ==== bench/mesh_network_asserts.sv ====
// Mesh network node port checks
// Held output data stays put, outputs idle right after reset

`timescale 1ns/1ps

module mesh_network_asserts #(
  parameter int NODES = 9
) (
  input logic              clk,
  input logic              i_rst,
  input mesh_pkg::packet_t o_data     [NODES],
  input logic              o_data_val [NODES],
  input logic              i_en       [NODES]
);

  for (genvar n = 0; n < NODES; n++) begin : g_node
    // Packet waits for the node's enable
    hold_stable : assert property (
      @(posedge clk) disable iff (i_rst)
      (o_data_val[n] && !i_en[n]) |=> (o_data_val[n] && $stable(o_data[n]))
    ) else $error("node %0d output packet changed while held", n);

    reset_idle : assert property (
      @(posedge clk) i_rst |=> !o_data_val[n]
    ) else $error("node %0d output valid high right after reset", n);
  end

endmodule

bind mesh_network mesh_network_asserts #(
  .NODES (X_NODES * Y_NODES)
) asserts_i (
  .clk,
  .i_rst,
  .o_data,
  .o_data_val,
  .i_en
);

// ==== bench/mesh_network_tb.sv ====
// Mesh NoC testbench
// Directed and random traffic on a 3 x 3 mesh, per-pair scoreboard

`timescale 1ns/1ps

module mesh_network_tb;

  localparam int X_NODES     = 3;
  localparam int Y_NODES     = 3;
  localparam int NODES       = X_NODES * Y_NODES;
  localparam int HOLD_NODE   = 4;       // Centre node, stalled 200 cycles
  localparam int MAX_CYCLES  = 20000;   // ~2200 packets, worst hops and stalls, margin
  localparam int DRAIN_LIMIT = 1000;    // Mesh empties well within this

  logic              clk;
  logic              rst;
  mesh_pkg::packet_t i_data     [NODES];
  logic              i_data_val [NODES];
  logic              o_en       [NODES];
  mesh_pkg::packet_t o_data     [NODES];
  logic              o_data_val [NODES];
  logic              i_en       [NODES];

  mesh_pkg::packet_t sb_q [NODES*NODES][$];   // Indexed src*NODES+dst
  int errors        = 0;
  int checks        = 0;
  int outstanding   = 0;   // Accepted, not yet delivered
  int cycles        = 0;
  int en_low_cycles = 0;

  mesh_network #(
    .X_NODES    (X_NODES),
    .Y_NODES    (Y_NODES),
    .FIFO_DEPTH (4)
  ) dut_i (
    .clk,
    .i_rst      (rst),
    .i_data,
    .i_data_val,
    .o_en,
    .o_data,
    .o_data_val,
    .i_en
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d packets still in flight", cycles, outstanding);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic int node_index(input logic [2:0] x, input logic [2:0] y);
    return int'(y) * X_NODES + int'(x);   // y*X_NODES + x
  endfunction

  function automatic mesh_pkg::packet_t make_packet(input int src, input int dst,
                                                    input logic [15:0] payload);
    mesh_pkg::packet_t p;
    p.dest_x  = 3'(dst % X_NODES);
    p.dest_y  = 3'(dst / X_NODES);
    p.src_x   = 3'(src % X_NODES);
    p.src_y   = 3'(src / X_NODES);
    p.payload = payload;
    return p;
  endfunction

  // Scoreboard, sampled mid-cycle
  // ------------------------------
  always @(negedge clk) begin : monitor
    mesh_pkg::packet_t want;
    int src;
    int dst;
    if (!rst) begin
      for (int n = 0; n < NODES; n++) begin
        if (!o_en[n])
          en_low_cycles++;
        if (i_data_val[n] && o_en[n]) begin   // Accepted on next edge
          dst = node_index(i_data[n].dest_x, i_data[n].dest_y);
          sb_q[n*NODES + dst].push_back(i_data[n]);
          outstanding++;
        end
        if (o_data_val[n] && i_en[n]) begin   // Delivered on next edge
          checks++;
          dst = node_index(o_data[n].dest_x, o_data[n].dest_y);
          src = node_index(o_data[n].src_x, o_data[n].src_y);
          assert (dst == n) else begin
            $display("Fail %0t: o_data[%0d] dest node expected %0d got %0d", $time, n, n, dst);
            errors++;
          end
          assert (src < NODES && sb_q[src*NODES + n].size() != 0) else begin
            $display("Packet at node %0d claims source %0d but none is outstanding", n, src);
            errors++;
          end
          if (src < NODES && sb_q[src*NODES + n].size() != 0) begin
            want = sb_q[src*NODES + n].pop_front();   // Oldest of the pair
            outstanding--;
            assert (o_data[n] == want) else begin
              $display("Fail %0t: o_data[%0d] expected %h got %h", $time, n, want, o_data[n]);
              errors++;
            end
          end
        end
      end
    end
  end

  // Stimulus tasks
  // ------------------------------
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (outstanding != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    #1;
  endtask

  task automatic send_one(input int src, input int dst, input logic [15:0] payload);
    i_data[src]     = make_packet(src, dst, payload);
    i_data_val[src] = 1'b1;
    do
      @(negedge clk);
    while (!o_en[src]);   // Taken on the coming edge
    @(posedge clk);
    #1;
    i_data_val[src] = 1'b0;
    wait_drained();
  endtask

  function automatic bit any_valid();
    for (int n = 0; n < NODES; n++)
      if (i_data_val[n])
        return 1'b1;
    return 1'b0;
  endfunction

  task automatic random_traffic(input int total, input bit backpress);
    int issued;
    int bp_cycle;
    bit take [NODES];
    issued   = 0;
    bp_cycle = 0;
    while (issued < total || any_valid() || (backpress && bp_cycle < 200)) begin
      @(negedge clk);
      for (int n = 0; n < NODES; n++)
        take[n] = i_data_val[n] && o_en[n];
      @(posedge clk);
      #1;
      for (int n = 0; n < NODES; n++) begin
        if (take[n] || !i_data_val[n]) begin
          // Slot free, new packet or a gap
          if (issued < total && $urandom % 3 != 0) begin
            i_data[n]     = make_packet(n, int'($urandom % NODES), 16'($urandom));
            i_data_val[n] = 1'b1;
            issued++;
          end else begin
            i_data_val[n] = 1'b0;
          end
        end
        if (backpress)
          i_en[n] = (n == HOLD_NODE && bp_cycle < 200) ? 1'b0 : ($urandom % 4 != 0);
      end
      bp_cycle++;
    end
    for (int n = 0; n < NODES; n++)
      i_en[n] = 1'b1;   // Let everything drain
    wait_drained();
  endtask

  // Test sequence
  // ------------------------------
  initial begin
    void'($urandom(32'hcda8));
    rst = 1'b1;
    for (int n = 0; n < NODES; n++) begin
      i_data[n]     = '0;
      i_data_val[n] = 1'b0;
      i_en[n]       = 1'b1;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    for (int n = 0; n < NODES; n++)
      assert (o_data_val[n] == 1'b0) else begin
        $display("Fail %0t: o_data_val[%0d] expected 0 got %b", $time, n, o_data_val[n]);
        errors++;
      end
    @(posedge clk);
    @(negedge clk);
    for (int n = 0; n < NODES; n++)
      assert (o_en[n] == 1'b1) else begin
        $display("Fail %0t: o_en[%0d] expected 1 got %b", $time, n, o_en[n]);
        errors++;
      end
    @(posedge clk);
    #1;

    for (int s = 0; s < NODES; s++)   // Every pair, one at a time
      for (int d = 0; d < NODES; d++)
        if (s != d)
          send_one(s, d, 16'($urandom));
    for (int n = 0; n < NODES; n++)   // Back to itself
      send_one(n, n, 16'($urandom));

    random_traffic(1500, 1'b0);
    en_low_cycles = 0;
    random_traffic(600, 1'b1);
    assert (en_low_cycles > 0) else begin
      $display("Sources never saw o_en drop during back-pressure");
      errors++;
    end

    for (int p = 0; p < NODES*NODES; p++)
      assert (sb_q[p].size() == 0) else begin
        $display("%0d packets from node %0d to node %0d never delivered",
                 sb_q[p].size(), p / NODES, p % NODES);
        errors++;
      end

    $display("Packets checked %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== mesh_noc.f ====
verilog/mesh_pkg.sv
verilog/mesh_input_fifo.sv
verilog/mesh_route_arbiter.sv
verilog/mesh_router.sv
verilog/mesh_network.sv
bench/mesh_network_asserts.sv
bench/mesh_network_tb.sv

// ==== Makefile ====
# Verilator build and run for the mesh NoC testbench

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes
obj_dir/Vmesh_network_tb: mesh_noc.f $(shell cat mesh_noc.f)
	verilator --binary --timing --assert -j 0 --top-module mesh_network_tb -f mesh_noc.f

# Pass only if the log holds the pass line
run: obj_dir/Vmesh_network_tb
	./obj_dir/Vmesh_network_tb | tee sim.log
	grep -q '^TEST PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
